// File: hw/rvPkg.sv
// RV32I word-only subset; FENCE and SYSTEM are not decoded and fall through as rd writes
package rvPkg;

        // Datapath and memory geometry
        localparam int xlen        = 32;
        localparam int regCount    = 32;
        localparam int ramWords    = 16384;
        localparam int ramAddrBits = $clog2(ramWords);
        // Address bit that moves an access from RAM to the I/O window
        localparam int ioSelectBit = 22;

        // Kept major opcodes
        localparam logic [6:0] opLui    = 7'b0110111;
        localparam logic [6:0] opAuipc  = 7'b0010111;
        localparam logic [6:0] opJal    = 7'b1101111;
        localparam logic [6:0] opJalr   = 7'b1100111;
        localparam logic [6:0] opBranch = 7'b1100011;
        localparam logic [6:0] opLoad   = 7'b0000011;
        localparam logic [6:0] opStore  = 7'b0100011;
        localparam logic [6:0] opAluImm = 7'b0010011;
        localparam logic [6:0] opAluReg = 7'b0110011;

        // Bubble, add x0,x0,x0
        localparam logic [31:0] nopInstr = 32'h0000_0033;

        typedef logic [xlen-1:0] word_t;
        typedef logic [4:0]      regId_t;

        typedef struct packed {
                word_t pc;
                word_t instr;
                logic  bubble;
        } fdReg_t;

        typedef struct packed {
                word_t pc;
                word_t instr;
                word_t rs1Val;
                word_t rs2Val;
        } deReg_t;

        typedef struct packed {
                word_t instr;
                word_t result;
                word_t addr;
                word_t rs2Val;
        } emReg_t;

        typedef struct packed {
                word_t instr;
                word_t result;
                word_t addr;
                word_t ioData;
        } mwReg_t;

        typedef struct packed {
                logic  taken;
                word_t target;
        } redirect_t;

        typedef struct packed {
                logic   enable;
                regId_t rd;
                word_t  data;
        } wbReq_t;

        // Instruction fields
        function automatic logic [6:0] opcode(word_t instr);
                return instr[6:0];
        endfunction

        function automatic logic [2:0] funct3(word_t instr);
                return instr[14:12];
        endfunction

        function automatic regId_t rs1Id(word_t instr);
                return instr[19:15];
        endfunction

        function automatic regId_t rs2Id(word_t instr);
                return instr[24:20];
        endfunction

        function automatic regId_t rdId(word_t instr);
                return instr[11:7];
        endfunction

        // Sign-extended immediates per format
        function automatic word_t iImm(word_t instr);
                return {{21{instr[31]}}, instr[30:20]};
        endfunction

        function automatic word_t sImm(word_t instr);
                return {{21{instr[31]}}, instr[30:25], instr[11:7]};
        endfunction

        function automatic word_t bImm(word_t instr);
                return {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        endfunction

        function automatic word_t uImm(word_t instr);
                return {instr[31:12], 12'b0};
        endfunction

        function automatic word_t jImm(word_t instr);
                return {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        endfunction

        // Register usage, used by hazard detection and writeback
        function automatic logic writesRd(word_t instr);
                return opcode(instr) != opStore && opcode(instr) != opBranch;
        endfunction

        function automatic logic readsRs1(word_t instr);
                return opcode(instr) != opJal && opcode(instr) != opAuipc
                        && opcode(instr) != opLui;
        endfunction

        function automatic logic readsRs2(word_t instr);
                return opcode(instr) == opAluReg || opcode(instr) == opBranch
                        || opcode(instr) == opStore;
        endfunction

endpackage

// File: hw/fetchStage.sv
// imemData must be valid in the same cycle as imemAddr; a redirect beats a stall
`timescale 1ns/10ps

module fetchStage
        import rvPkg::*;
(
        input  logic      clk,
        input  logic      reset,
        input  logic      stall,
        input  redirect_t redirect,
        output word_t     imemAddr,
        input  word_t     imemData,
        output fdReg_t    fd
);

        word_t pc;

        // Instruction port follows the live pc
        assign imemAddr = pc;

        always_ff @(posedge clk) begin
                if (reset) begin
                        pc <= '0;
                end else if (redirect.taken) begin
                        pc <= redirect.target;
                end else if (!stall) begin
                        pc <= pc + 32'd4;
                end
        end

        always_ff @(posedge clk) begin
                // Hold the fetched word while decode waits
                if (!stall) begin
                        fd.pc    <= pc;
                        fd.instr <= imemData;
                end
                // Wrong-path or reset fetch becomes a bubble
                fd.bubble <= reset | redirect.taken;
        end

endmodule

// File: hw/decodeStage.sv
// No forwarding; decode waits until every pending producer has written back
`timescale 1ns/10ps

module decodeStage
        import rvPkg::*;
(
        input  logic      clk,
        input  logic      reset,
        input  fdReg_t    fd,
        input  redirect_t redirect,
        input  word_t     emInstr,
        input  word_t     mwInstr,
        input  wbReq_t    wb,
        output logic      stall,
        output deReg_t    de
);

        word_t  regFile [regCount];
        regId_t rs1;
        regId_t rs2;
        logic   rs1Hazard;
        logic   rs2Hazard;
        logic   squash;

        // Does instr still owe a write to src
        function automatic logic pendingWrite(word_t instr, regId_t src);
                return writesRd(instr) && rdId(instr) == src;
        endfunction

        assign rs1 = rs1Id(fd.instr);
        assign rs2 = rs2Id(fd.instr);

        // Producers in execute, memory and writeback
        assign rs1Hazard = !fd.bubble && readsRs1(fd.instr) && rs1 != '0
                && (pendingWrite(de.instr, rs1) || pendingWrite(emInstr, rs1)
                || pendingWrite(mwInstr, rs1));

        assign rs2Hazard = !fd.bubble && readsRs2(fd.instr) && rs2 != '0
                && (pendingWrite(de.instr, rs2) || pendingWrite(emInstr, rs2)
                || pendingWrite(mwInstr, rs2));

        assign stall = rs1Hazard | rs2Hazard;

        // Anything that must not reach execute
        assign squash = reset | redirect.taken | stall | fd.bubble;

        // Writeback port
        always_ff @(posedge clk) begin
                if (wb.enable) begin
                        regFile[wb.rd] <= wb.data;
                end
        end

        always_ff @(posedge clk) begin
                de.pc    <= fd.pc;
                de.instr <= squash ? nopInstr : fd.instr;
                // Entry 0 is never trusted, x0 reads as zero
                de.rs1Val <= (rs1 == '0) ? '0 : regFile[rs1];
                de.rs2Val <= (rs2 == '0) ? '0 : regFile[rs2];
        end

endmodule

// File: hw/executeStage.sv
// Branches and jumps resolve here; redirect is combinational off the decode/execute register
`timescale 1ns/10ps

module executeStage
        import rvPkg::*;
(
        input  logic      clk,
        input  logic      reset,
        input  deReg_t    de,
        output redirect_t redirect,
        output emReg_t    em
);

        logic [6:0] op;
        logic [2:0] f3;
        logic [4:0] shamt;
        word_t      aluIn1;
        word_t      aluIn2;
        word_t      aluPlus;
        word_t      shiftRight;
        word_t      aluOut;
        word_t      result;
        word_t      addr;
        logic       lt;
        logic       ltu;
        logic       eq;
        logic       takeBranch;

        assign op = opcode(de.instr);
        assign f3 = funct3(de.instr);

        // Second operand is rs2 for R-type and branches, else the I immediate
        assign aluIn1 = de.rs1Val;
        assign aluIn2 = (op == opAluReg || op == opBranch) ? de.rs2Val : iImm(de.instr);
        assign shamt  = aluIn2[4:0];

        assign aluPlus = aluIn1 + aluIn2;
        assign lt      = $signed(aluIn1) < $signed(aluIn2);
        assign ltu     = aluIn1 < aluIn2;
        assign eq      = aluIn1 == aluIn2;

        // Bit 30 picks arithmetic shift for both SRA and SRAI
        always_comb begin
                if (de.instr[30]) begin
                        shiftRight = word_t'($signed(aluIn1) >>> shamt);
                end else begin
                        shiftRight = aluIn1 >> shamt;
                end
        end

        always_comb begin
                case (f3)
                        // SUB only exists in the register form
                        3'b000:  aluOut = (op == opAluReg && de.instr[30]) ?
                                          aluIn1 - aluIn2 : aluPlus;
                        3'b001:  aluOut = aluIn1 << shamt;
                        3'b010:  aluOut = {31'b0, lt};
                        3'b011:  aluOut = {31'b0, ltu};
                        3'b100:  aluOut = aluIn1 ^ aluIn2;
                        3'b101:  aluOut = shiftRight;
                        3'b110:  aluOut = aluIn1 | aluIn2;
                        default: aluOut = aluIn1 & aluIn2;
                endcase
        end

        // Branch condition from funct3
        always_comb begin
                case (f3)
                        3'b000:  takeBranch = eq;
                        3'b001:  takeBranch = !eq;
                        3'b100:  takeBranch = lt;
                        3'b101:  takeBranch = !lt;
                        3'b110:  takeBranch = ltu;
                        3'b111:  takeBranch = !ltu;
                        default: takeBranch = 1'b0;
                endcase
        end

        assign redirect.taken = op == opJal || op == opJalr || (op == opBranch && takeBranch);

        // JALR clears the low target bit
        always_comb begin
                case (op)
                        opBranch: redirect.target = de.pc + bImm(de.instr);
                        opJal:    redirect.target = de.pc + jImm(de.instr);
                        default:  redirect.target = {aluPlus[31:1], 1'b0};
                endcase
        end

        // Unknown opcodes still write rd, with zero
        always_comb begin
                case (op)
                        opLui:    result = uImm(de.instr);
                        opAuipc:  result = de.pc + uImm(de.instr);
                        opJal,
                        opJalr:   result = de.pc + 32'd4;
                        opAluImm,
                        opAluReg: result = aluOut;
                        default:  result = '0;
                endcase
        end

        // Effective address for loads and stores
        assign addr = de.rs1Val + ((op == opStore) ? sImm(de.instr) : iImm(de.instr));

        always_ff @(posedge clk) begin
                em.instr  <= reset ? nopInstr : de.instr;
                em.result <= result;
                em.addr   <= addr;
                em.rs2Val <= de.rs2Val;
        end

endmodule

// File: hw/memoryStage.sv
// Word accesses only; RAM contents are undefined at start and the I/O port cannot stall
`timescale 1ns/10ps

module memoryStage
        import rvPkg::*;
(
        input  logic   clk,
        input  logic   reset,
        input  emReg_t em,
        output word_t  ioAddr,
        output word_t  ioWData,
        output logic   ioWr,
        input  word_t  ioRData,
        output word_t  mwInstr,
        output wbReq_t wb
);

        word_t                  ram [ramWords];
        logic [ramAddrBits-1:0] wordAddr;
        logic                   isIo;
        logic                   isStore;
        word_t                  ramRData;
        mwReg_t                 mw;

        // Bit ioSelectBit splits RAM from the I/O window
        assign isIo     = em.addr[ioSelectBit];
        assign isStore  = opcode(em.instr) == opStore;
        assign wordAddr = em.addr[ramAddrBits+1:2];

        assign ioAddr  = em.addr;
        assign ioWData = em.rs2Val;
        // One pulse per I/O store, as em holds it for one cycle
        assign ioWr    = isStore && isIo;

        // Synchronous read lands beside the memory/writeback register
        always_ff @(posedge clk) begin
                if (isStore && !isIo) begin
                        ram[wordAddr] <= em.rs2Val;
                end
                ramRData <= ram[wordAddr];
        end

        always_ff @(posedge clk) begin
                mw.instr  <= reset ? nopInstr : em.instr;
                mw.result <= em.result;
                mw.addr   <= em.addr;
                mw.ioData <= ioRData;
        end

        assign mwInstr = mw.instr;

        // Writeback selection
        assign wb.enable = writesRd(mw.instr) && rdId(mw.instr) != '0;
        assign wb.rd     = rdId(mw.instr);
        assign wb.data   = (opcode(mw.instr) != opLoad) ? mw.result :
                           mw.addr[ioSelectBit]        ? mw.ioData : ramRData;

endmodule

// File: hw/rvCore.sv
// Five-stage RV32I core; instruction port is combinational, no external back-pressure
`timescale 1ns/10ps

module rvCore
        import rvPkg::*;
(
        input  logic  clk,
        input  logic  reset,
        output word_t imemAddr,
        input  word_t imemData,
        output word_t ioAddr,
        output word_t ioWData,
        output logic  ioWr,
        input  word_t ioRData
);

        fdReg_t    fd;
        deReg_t    de;
        emReg_t    em;
        redirect_t redirect;
        wbReq_t    wb;
        word_t     mwInstr;
        logic      stall;

        fetchStage u_fetchStage (
                .clk      (clk),
                .reset    (reset),
                .stall    (stall),
                .redirect (redirect),
                .imemAddr (imemAddr),
                .imemData (imemData),
                .fd       (fd)
        );

        // Hazard check sees the memory-stage instruction straight from em
        decodeStage u_decodeStage (
                .clk      (clk),
                .reset    (reset),
                .fd       (fd),
                .redirect (redirect),
                .emInstr  (em.instr),
                .mwInstr  (mwInstr),
                .wb       (wb),
                .stall    (stall),
                .de       (de)
        );

        executeStage u_executeStage (
                .clk      (clk),
                .reset    (reset),
                .de       (de),
                .redirect (redirect),
                .em       (em)
        );

        memoryStage u_memoryStage (
                .clk      (clk),
                .reset    (reset),
                .em       (em),
                .ioAddr   (ioAddr),
                .ioWData  (ioWData),
                .ioWr     (ioWr),
                .ioRData  (ioRData),
                .mwInstr  (mwInstr),
                .wb       (wb)
        );

endmodule

// File: verification/rvCoreTb.sv
// Directed tests only; program words above 1 KB read as NOPs and the data RAM is never preloaded
`timescale 1ns/10ps

module rvCoreTb
        import rvPkg::*;
();

        logic  clk;
        logic  reset;
        word_t imemAddr;
        word_t imemData;
        word_t ioAddr;
        word_t ioWData;
        logic  ioWr;
        word_t ioRData;

        // Program store, answered combinationally on the instruction port
        word_t  imem [256];
        int     progLen;
        // Expected I/O writes in program order
        word_t  expAddr [$];
        word_t  expData [$];
        integer seed;

        rvCore u_rvCore (
                .clk      (clk),
                .reset    (reset),
                .imemAddr (imemAddr),
                .imemData (imemData),
                .ioAddr   (ioAddr),
                .ioWData  (ioWData),
                .ioWr     (ioWr),
                .ioRData  (ioRData)
        );

        // Past the program store the core only sees NOPs
        assign imemData = (imemAddr < 32'd1024) ? imem[imemAddr[9:2]] : nopInstr;

        initial begin
                clk = 1'b0;
                forever begin
                        #10 clk = ~clk;
                end
        end

        // RV32I instruction formats
        function automatic word_t encR(logic [6:0] f7, regId_t rs2, regId_t rs1,
                                       logic [2:0] f3, regId_t rd);
                return {f7, rs2, rs1, f3, rd, opAluReg};
        endfunction

        function automatic word_t encI(logic [11:0] imm, regId_t rs1, logic [2:0] f3,
                                       regId_t rd, logic [6:0] op);
                return {imm, rs1, f3, rd, op};
        endfunction

        // Word store with funct3 010
        function automatic word_t encS(logic [11:0] imm, regId_t rs2, regId_t rs1);
                return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
        endfunction

        function automatic word_t encB(logic [12:0] imm, regId_t rs2, regId_t rs1,
                                       logic [2:0] f3);
                return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
        endfunction

        function automatic word_t encU(logic [19:0] imm, regId_t rd, logic [6:0] op);
                return {imm, rd, op};
        endfunction

        function automatic word_t encJ(logic [20:0] imm, regId_t rd);
                return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
        endfunction

        function automatic word_t signExtend12(logic [11:0] v);
                return {{20{v[11]}}, v};
        endfunction

        // Reference ALU where alt selects SUB or SRA
        function automatic word_t aluModel(logic alt, logic [2:0] f3, word_t x, word_t y);
                case (f3)
                        3'b000:  return alt ? x - y : x + y;
                        3'b001:  return x << y[4:0];
                        3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
                        3'b011:  return (x < y) ? 32'd1 : 32'd0;
                        3'b100:  return x ^ y;
                        3'b101:  return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
                        3'b110:  return x | y;
                        default: return x & y;
                endcase
        endfunction

        // Reference branch condition
        function automatic logic branchTaken(logic [2:0] f3, word_t x, word_t y);
                case (f3)
                        3'b000:  return x == y;
                        3'b001:  return x != y;
                        3'b100:  return $signed(x) < $signed(y);
                        3'b101:  return $signed(x) >= $signed(y);
                        3'b110:  return x < y;
                        3'b111:  return x >= y;
                        default: return 1'b0;
                endcase
        endfunction

        // Byte address of an I/O slot off the window base that x1 holds
        function automatic word_t ioSlotAddr(int slot);
                return (word_t'(1) << ioSelectBit) + word_t'(slot * 4);
        endfunction

        function automatic word_t nextPc();
                return word_t'(progLen * 4);
        endfunction

        task automatic abortRun(input string why);
                $display("%s", why);
                $display("Done: errors found");
                $fatal(1, "Simulation stopped at the first error");
        endtask

        task automatic emit(input word_t instr);
                imem[progLen[7:0]] = instr;
                progLen++;
        endtask

        // LUI plus ADDI with the upper part rounded for the signed low half
        task automatic loadConst(input regId_t rd, input word_t value);
                word_t upper;
                upper = value + 32'h800;
                emit(encU(upper[31:12], rd, opLui));
                emit(encI(value[11:0], rd, 3'b000, rd, opAluImm));
        endtask

        task automatic storeIo(input regId_t rs2, input int slot, input word_t value);
                emit(encS(12'(slot * 4), rs2, 5'd1));
                expAddr.push_back(ioSlotAddr(slot));
                expData.push_back(value);
        endtask

        // Core held in reset while a fresh program is written
        task automatic beginProgram();
                reset = 1'b1;
                for (int i = 0; i < 256; i++) begin
                        imem[i[7:0]] = nopInstr;
                end
                progLen = 0;
                expAddr.delete();
                expData.delete();
                loadConst(5'd1, ioSlotAddr(0));
        endtask

        task automatic waitIoWrite(input string name, output word_t addr, output word_t data);
                int cycles;
                cycles = 0;
                @(negedge clk);
                while (!ioWr && cycles < 2000) begin
                        @(negedge clk);
                        cycles++;
                end
                if (!ioWr) begin
                        abortRun($sformatf("Timeout in %s: no I/O write within 2000 cycles",
                                           name));
                end
                addr = ioAddr;
                data = ioWData;
        endtask

        // Release reset and match every I/O write in order
        task automatic runProgram(input string name);
                word_t addr;
                word_t data;
                repeat (5) @(negedge clk);
                // Fetch starts from address zero
                assert (imemAddr == 32'd0) else
                        abortRun($sformatf("CHECK FAILED %s imemAddr expected %h actual %h",
                                           name, 32'd0, imemAddr));
                reset = 1'b0;
                while (expAddr.size() > 0) begin
                        waitIoWrite(name, addr, data);
                        assert (addr == expAddr[0]) else
                                abortRun($sformatf("CHECK FAILED %s ioAddr expected %h actual %h",
                                                   name, expAddr[0], addr));
                        assert (data == expData[0]) else
                                abortRun($sformatf("CHECK FAILED %s ioWData expected %h actual %h",
                                                   name, expData[0], data));
                        void'(expAddr.pop_front());
                        void'(expData.pop_front());
                end
        endtask

        task automatic testAlu();
                word_t       a;
                word_t       b;
                word_t       r;
                logic [3:0]  code;
                logic [11:0] imm;
                int          slot;
                beginProgram();
                a = $random(seed);
                b = $random(seed);
                loadConst(5'd2, a);
                loadConst(5'd3, b);
                slot = 0;
                for (int c = 0; c < 16; c++) begin
                        code = 4'(c);
                        // Alternate encoding only for SUB and SRA
                        if (code[3] && code[2:0] != 3'b000 && code[2:0] != 3'b101) begin
                                continue;
                        end
                        emit(encR(code[3] ? 7'h20 : 7'h00, 5'd3, 5'd2, code[2:0], 5'd4));
                        storeIo(5'd4, slot, aluModel(code[3], code[2:0], a, b));
                        slot++;
                        // SUB has no immediate twin
                        if (code == 4'b1000) begin
                                continue;
                        end
                        r = $random(seed);
                        // Shifts carry shamt and bit 30 in the immediate
                        if (code[1:0] == 2'b01) begin
                                imm = {1'b0, code[3], 5'b0, r[4:0]};
                        end else begin
                                imm = r[11:0];
                        end
                        emit(encI(imm, 5'd2, code[2:0], 5'd5, opAluImm));
                        storeIo(5'd5, slot, aluModel(code[3], code[2:0], a, signExtend12(imm)));
                        slot++;
                end
                runProgram("alu");
        endtask

        task automatic testDependence();
                word_t       v;
                word_t       r;
                logic [11:0] c1;
                logic [11:0] c2;
                beginProgram();
                v = $random(seed);
                r = $random(seed);
                c1 = r[11:0];
                c2 = r[23:12];
                loadConst(5'd2, v);
                // Each step reads the one before it
                emit(encI(c1, 5'd2, 3'b000, 5'd3, opAluImm));
                emit(encR(7'h00, 5'd3, 5'd3, 3'b000, 5'd4));
                emit(encI(c2, 5'd4, 3'b100, 5'd5, opAluImm));
                emit(encR(7'h20, 5'd2, 5'd5, 3'b000, 5'd6));
                emit(encI(12'h403, 5'd6, 3'b101, 5'd7, opAluImm));
                r = v + signExtend12(c1);
                r = r + r;
                r = r ^ signExtend12(c2);
                r = r - v;
                r = word_t'($signed(r) >>> 3);
                storeIo(5'd7, 0, r);
                runProgram("dependence");
        endtask

        task automatic testBranches();
                word_t      p;
                word_t      q;
                word_t      va;
                word_t      vb;
                regId_t     rs1;
                regId_t     rs2;
                logic [2:0] f3;
                int         slot;
                beginProgram();
                // Negative p and positive q split signed and unsigned order
                p = $random(seed) | 32'h8000_0000;
                q = $random(seed) & 32'h7fff_ffff;
                loadConst(5'd2, p);
                loadConst(5'd3, q);
                slot = 0;
                for (int f = 0; f < 8; f++) begin
                        f3 = 3'(f);
                        if (f3 == 3'b010 || f3 == 3'b011) begin
                                continue;
                        end
                        for (int k = 0; k < 3; k++) begin
                                rs1 = (k == 2) ? 5'd3 : 5'd2;
                                rs2 = (k == 1) ? 5'd3 : 5'd2;
                                va = (k == 2) ? q : p;
                                vb = (k == 1) ? q : p;
                                emit(encI(12'd0, 5'd0, 3'b000, 5'd8, opAluImm));
                                // Taken lands on the store past both markers
                                emit(encB(13'd12, rs2, rs1, f3));
                                emit(encI(12'd1, 5'd0, 3'b000, 5'd8, opAluImm));
                                emit(encI(12'd2, 5'd8, 3'b000, 5'd8, opAluImm));
                                storeIo(5'd8, slot, branchTaken(f3, va, vb) ? 32'd0 : 32'd3);
                                slot++;
                        end
                end
                runProgram("branch");
        endtask

        task automatic testJumps();
                word_t here;
                word_t target;
                word_t r;
                beginProgram();
                emit(encI(12'd0, 5'd0, 3'b000, 5'd6, opAluImm));
                here = nextPc();
                emit(encJ(21'd12, 5'd5));
                // Both skipped so x6 must stay zero
                emit(encI(12'd1, 5'd0, 3'b000, 5'd6, opAluImm));
                emit(encI(12'd2, 5'd0, 3'b000, 5'd6, opAluImm));
                storeIo(5'd5, 0, here + 32'd4);
                here = nextPc();
                target = here + 32'd16;
                emit(encI(target[11:0], 5'd0, 3'b000, 5'd7, opAluImm));
                // Odd sum whose low bit JALR drops
                emit(encI(12'd1, 5'd7, 3'b000, 5'd10, opJalr));
                emit(encI(12'd3, 5'd0, 3'b000, 5'd6, opAluImm));
                emit(encI(12'd4, 5'd0, 3'b000, 5'd6, opAluImm));
                storeIo(5'd10, 1, here + 32'd8);
                storeIo(5'd6, 2, 32'd0);
                r = $random(seed);
                emit(encU(r[19:0], 5'd12, opLui));
                storeIo(5'd12, 3, {r[19:0], 12'b0});
                here = nextPc();
                emit(encU(r[31:12], 5'd13, opAuipc));
                storeIo(5'd13, 4, here + {r[31:12], 12'b0});
                runProgram("jump");
        endtask

        task automatic testDataRam();
                word_t       w [5];
                word_t       base;
                logic [11:0] off [5];
                beginProgram();
                // Base keeps every address inside the RAM and out of the I/O window
                base = 32'h1000 + ($random(seed) & 32'h0000_e000);
                off = '{12'h000, 12'h104, 12'h3fc, 12'h7fc, 12'h800};
                loadConst(5'd15, base);
                for (int i = 0; i < 5; i++) begin
                        w[i] = $random(seed);
                        loadConst(regId_t'(16 + i), w[i]);
                        emit(encS(off[i], regId_t'(16 + i), 5'd15));
                end
                // Read back in reverse order
                for (int i = 4; i >= 0; i--) begin
                        emit(encI(off[i], 5'd15, 3'b010, regId_t'(21 + i), opLoad));
                end
                for (int i = 0; i < 5; i++) begin
                        storeIo(regId_t'(21 + i), i, w[i]);
                end
                // A stray RAM ioWr would show up first with the wrong address
                runProgram("dataRam");
        endtask

        task automatic testIoRead();
                word_t r;
                beginProgram();
                r = $random(seed);
                ioRData = r;
                emit(encI(12'h020, 5'd1, 3'b010, 5'd26, opLoad));
                emit(encI(12'd1, 5'd26, 3'b000, 5'd27, opAluImm));
                storeIo(5'd27, 9, r + 32'd1);
                runProgram("ioRead");
        endtask

        initial begin
                seed = 32'h50a7bc5b;
                reset = 1'b1;
                ioRData = '0;
                progLen = 0;
                testAlu();
                testDependence();
                testBranches();
                testJumps();
                testDataRam();
                testIoRead();
                $display("Done: no errors");
                $finish;
        end

endmodule

// File: all.f
hw/rvPkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/rvCore.sv
verification/rvCoreTb.sv

// File: run.sh
#!/bin/bash
# Build and run the rvCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rvCoreTb -f all.f > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/VrvCoreTb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
    exit 0
fi
echo "Pass message missing from sim.log"
exit 1
